//--- filelist.f
rtl/detPkg.sv
rtl/detRamIf.sv
rtl/pipeMultiplier.sv
rtl/matrixRam.sv
rtl/matrixLoader.sv
rtl/diagProduct.sv
rtl/cmdControl.sv
rtl/detTop.sv
tests/tbClockGen.sv
tests/detProtocol_checker.sv
tests/detTb.sv

//--- tests/detTb.sv
// testbench for the determinant accelerator with a random-latency read slave model
`timescale 1ns/10ps
`default_nettype none

module detTb;
    import detPkg::*;

    localparam int mulLatency = 5;
    localparam int numRows    = 7;

    // base address, dimension, zeroed diagonal position (-1 for none)
    localparam int rowBase [numRows] = '{'h000100, 'h001000, 'h123450, 'h040000,
                                         'h200004, 'h010000, 'h00abc0};
    localparam int rowDim  [numRows] = '{2, 3, 5, 8, 4, 32, 6};
    localparam int rowZero [numRows] = '{-1, -1, 2, 0, 3, -1, 4};

    logic    clk;
    logic    arstN;
    logic    start = 1'b0;
    dataT    dataa = '0;
    dataT    datab = '0;
    logic    done;
    dataT    result;
    busAddrT address;
    logic    read;
    dataT    readdata = '0;
    logic    readdatavalid = 1'b0;
    logic    waitrequest = 1'b0;
    logic    resultRead = 1'b0;
    dataT    resultReaddata;
    logic    irq;

    integer  seed = 54917;
    int      errorCount = 0;
    int      cycleNo = 0;
    int      returnedCount = 0;
    dataT    expectedDet;
    dataT    memWords [1024];      // indexed by word address modulo 1024
    busAddrT acceptedAddr [$];
    dataT    pendData [$];
    int      pendReady [$];       // cycle from which each word may return

    tbClockGen clkGen_i (
        .clk   (clk),
        .arstN (arstN)
    );

    detTop #(
        .mulLatency (mulLatency)
    ) detTop_i (
        .clk            (clk),
        .arstN          (arstN),
        .start          (start),
        .dataa          (dataa),
        .datab          (datab),
        .done           (done),
        .result         (result),
        .address        (address),
        .read           (read),
        .readdata       (readdata),
        .readdatavalid  (readdatavalid),
        .waitrequest    (waitrequest),
        .resultRead     (resultRead),
        .resultReaddata (resultReaddata),
        .irq            (irq)
    );

    task automatic checkValue(input string name, input dataT expected, input dataT actual);
        if (actual !== expected) begin
            errorCount++;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    // one custom instruction with its reply due the cycle after start
    task automatic issueStart(input dataT a, input dataT b, input dataT expStatus);
        start = 1'b1;
        dataa = a;
        datab = b;
        @(posedge clk);
        #1;
        start = 1'b0;
        checkValue("done", 32'd1, done);
        checkValue("result", expStatus, result);
        @(posedge clk);
        #1;
    endtask

    task automatic fillMemory(input int r);
        busAddrT a;
        dataT    w;
        int      n;
        n = rowDim[r];
        expectedDet = 32'd1;
        for (int k = 0; k < n * n; k++) begin
            w = $random(seed);
            if (k % (n + 1) == 0) begin   // diagonal word
                if (w == '0) begin
                    w = 32'h1;
                end
                if (k / (n + 1) == rowZero[r]) begin
                    w = '0;
                end
                expectedDet = expectedDet * w;   // wraps mod 2^32
            end
            a = busAddrT'(rowBase[r] + 4 * k);
            memWords[a[11:2]] = w;
        end
    endtask

    task automatic waitIrq(input int limit);
        int n;
        n = 0;
        while (!irq && n < limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!irq) begin
            errorCount++;
            $display("irq did not rise within %0d cycles after the load", limit);
        end
    endtask

    task automatic checkAddresses(input int r);
        int n;
        n = rowDim[r] * rowDim[r];
        if (acceptedAddr.size() != n) begin
            errorCount++;
            $display("row %0d: %0d read requests accepted instead of %0d",
                     r, acceptedAddr.size(), n);
        end
        for (int k = 0; k < acceptedAddr.size() && k < n; k++) begin
            checkValue("address", 32'(busAddrT'(rowBase[r] + 4 * k)), 32'(acceptedAddr[k]));
        end
    endtask

    function automatic int runLimit();
        int total;
        total = 16 + 50;
        for (int r = 0; r < numRows; r++) begin
            total += rowDim[r] * rowDim[r] * 10 + rowDim[r] * (mulLatency + 3) + 200;
        end
        return total;
    endfunction

    // read slave with random stalls and in-order data after 1 to 4 cycles
    always @(posedge clk) begin
        #1;
        cycleNo++;
        readdatavalid = 1'b0;
        if (pendReady.size() > 0 && pendReady[0] <= cycleNo) begin
            readdatavalid = 1'b1;
            readdata      = pendData.pop_front();
            void'(pendReady.pop_front());
            returnedCount++;
        end
        waitrequest = (($random(seed) & 3) == 0);
        if (read && !waitrequest) begin   // taken at the coming edge
            acceptedAddr.push_back(address);
            pendData.push_back(memWords[address[11:2]]);
            pendReady.push_back(cycleNo + 1 + ($random(seed) & 3));
        end
    end

    initial begin
        repeat (runLimit()) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", runLimit());
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        wait (arstN === 1'b1);
        @(posedge clk);
        #1;
        for (int r = 0; r < numRows; r++) begin
            fillMemory(r);
            issueStart('0, 32'd0, STATUS_READY);
            issueStart('0, 32'd1, STATUS_READY);
            acceptedAddr.delete();
            returnedCount = 0;
            issueStart(dataT'(rowBase[r]), dataT'(rowDim[r]), STATUS_ACCEPTED);
            issueStart('0, 32'd5, STATUS_LOADING);
            wait (returnedCount == rowDim[r] * rowDim[r]);
            // loadDone and the move to CALC trail the last word by two cycles
            repeat (3) @(posedge clk);
            #1;
            issueStart('0, 32'd5, STATUS_COMPUTING);
            waitIrq(rowDim[r] * (mulLatency + 3) + 20);
            checkAddresses(r);
            issueStart('0, 32'd5, STATUS_IRQ_WAIT);
            checkValue("irq", 32'd1, irq);
            resultRead = 1'b1;
            @(posedge clk);
            #1;
            resultRead = 1'b0;
            checkValue("resultReaddata", expectedDet, resultReaddata);
            checkValue("irq", 32'd0, irq);
        end
        $display("errors: %0d testbench, %0d protocol",
                 errorCount, detTop_i.protocolCheck_i.failCount);
        if (errorCount == 0 && detTop_i.protocolCheck_i.failCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/detProtocol_checker.sv
// protocol assertions on the read master, the done pulse and the interrupt
`timescale 1ns/10ps
`default_nettype none

module detProtocol_checker (
    input logic            clk,
    input logic            arstN,
    input logic            read,
    input detPkg::busAddrT address,
    input logic            waitrequest,
    input logic            done,
    input logic            irq,
    input detPkg::stageT   stage
);
    import detPkg::*;

    int failCount = 0;   // assertion failures so far

    // a stalled request stays on the bus unchanged
    holdUnderWait: assert property (@(posedge clk) disable iff (!arstN)
        (read && waitrequest) |=> (read && $stable(address)))
        else begin
            failCount++;
            $error("read or address changed while waitrequest was high");
        end

    irqAfterReset: assert property (@(posedge clk) !arstN |=> !irq)
        else begin
            failCount++;
            $error("irq high right after reset");
        end

    doneSingle: assert property (@(posedge clk) disable iff (!arstN) done |=> !done)
        else begin
            failCount++;
            $error("done stayed high for two cycles");
        end

    readOnlyInLoad: assert property (@(posedge clk) disable iff (!arstN)
        $rose(read) |-> (stage == LOAD))
        else begin
            failCount++;
            $error("read rose outside the LOAD stage");
        end

endmodule

bind detTop detProtocol_checker protocolCheck_i (
    .clk         (clk),
    .arstN       (arstN),
    .read        (read),
    .address     (address),
    .waitrequest (waitrequest),
    .done        (done),
    .irq         (irq),
    .stage       (ctrl_i.stage)
);

`default_nettype wire

//--- tests/tbClockGen.sv
// testbench clock and reset source with a 20 ns period and reset held for 16 cycles
`timescale 1ns/10ps
`default_nettype none

module tbClockGen #(
    parameter int halfPeriod  = 10,
    parameter int resetCycles = 16
) (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    initial begin
        arstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #1;
        arstN = 1'b1;   // release away from the edge
    end

endmodule

`default_nettype wire

//--- rtl/detTop.sv
// determinant accelerator top with custom-instruction, read master and result ports
`timescale 1ns/10ps
`default_nettype none

module detTop #(
    parameter int mulLatency = 5
) (
    input  logic            clk,
    input  logic            arstN,
    // custom instruction
    input  logic            start,
    input  detPkg::dataT    dataa,
    input  detPkg::dataT    datab,
    output logic            done,
    output detPkg::dataT    result,
    // read master
    output detPkg::busAddrT address,
    output logic            read,
    input  detPkg::dataT    readdata,
    input  logic            readdatavalid,
    input  logic            waitrequest,
    // result port and interrupt
    input  logic            resultRead,
    output detPkg::dataT    resultReaddata,
    output logic            irq
);

    logic            loadStart;
    logic            loadDone;
    logic            calcStart;
    logic            calcDone;
    detPkg::busAddrT loadBase;
    detPkg::dimT     dim;
    detPkg::dataT    product;

    detRamIf ramBus ();

    cmdControl ctrl_i (
        .clk            (clk),
        .arstN          (arstN),
        .start          (start),
        .dataa          (dataa),
        .datab          (datab),
        .loadDone       (loadDone),
        .calcDone       (calcDone),
        .product        (product),
        .resultRead     (resultRead),
        .done           (done),
        .result         (result),
        .loadStart      (loadStart),
        .loadBase       (loadBase),
        .dim            (dim),
        .calcStart      (calcStart),
        .irq            (irq),
        .resultReaddata (resultReaddata)
    );

    matrixLoader loader_i (
        .clk           (clk),
        .arstN         (arstN),
        .loadStart     (loadStart),
        .loadBase      (loadBase),
        .dim           (dim),
        .readdata      (readdata),
        .readdatavalid (readdatavalid),
        .waitrequest   (waitrequest),
        .address       (address),
        .read          (read),
        .loadDone      (loadDone),
        .ram           (ramBus.writer)
    );

    matrixRam ram_i (
        .clk (clk),
        .ram (ramBus.mem)
    );

    diagProduct #(
        .mulLatency (mulLatency)
    ) diag_i (
        .clk       (clk),
        .arstN     (arstN),
        .calcStart (calcStart),
        .dim       (dim),
        .calcDone  (calcDone),
        .product   (product),
        .ram       (ramBus.reader)
    );

endmodule

`default_nettype wire

//--- rtl/cmdControl.sv
// stage machine answering custom-instruction starts and holding the result until read
`timescale 1ns/10ps
`default_nettype none

module cmdControl (
    input  logic            clk,
    input  logic            arstN,
    input  logic            start,
    input  detPkg::dataT    dataa,
    input  detPkg::dataT    datab,
    input  logic            loadDone,
    input  logic            calcDone,
    input  detPkg::dataT    product,
    input  logic            resultRead,
    output logic            done,
    output detPkg::dataT    result,
    output logic            loadStart,
    output detPkg::busAddrT loadBase,
    output detPkg::dimT     dim,
    output logic            calcStart,
    output logic            irq,
    output detPkg::dataT    resultReaddata
);
    import detPkg::*;

    stageT stage;
    dataT  finalResult;
    dataT  statusCode;
    logic  accept;

    // only an idle design with a real dimension takes a job
    assign accept = start && (stage == IDLE) && (datab > 32'd1);

    always_comb begin
        case (stage)
            IDLE:     statusCode = (datab > 32'd1) ? STATUS_ACCEPTED : STATUS_READY;
            LOAD:     statusCode = STATUS_LOADING;
            CALC:     statusCode = STATUS_COMPUTING;
            default:  statusCode = STATUS_IRQ_WAIT;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stage     <= IDLE;
            done      <= 1'b0;
            loadStart <= 1'b0;
            calcStart <= 1'b0;
            irq       <= 1'b0;
        end else begin
            done      <= start;    // one reply per start in any stage
            loadStart <= accept;
            calcStart <= 1'b0;
            case (stage)
                IDLE: begin
                    if (accept) stage <= LOAD;
                end
                LOAD: begin
                    if (loadDone) begin
                        stage     <= CALC;
                        calcStart <= 1'b1;
                    end
                end
                CALC: begin
                    if (calcDone) begin
                        stage <= IRQ_WAIT;
                        irq   <= 1'b1;
                    end
                end
                IRQ_WAIT: begin
                    if (resultRead) begin
                        stage <= IDLE;   // ready for the next job
                        irq   <= 1'b0;
                    end
                end
                default: stage <= IDLE;
            endcase
        end
    end

    // job parameters and result words
    always_ff @(posedge clk) begin
        if (accept) begin
            loadBase <= dataa[23:0];
            dim      <= datab[5:0];
        end
        if (start) result <= statusCode;
        if (stage == CALC && calcDone) finalResult <= product;
        if (stage == IRQ_WAIT && resultRead) resultReaddata <= finalResult;
    end

endmodule

`default_nettype wire

//--- rtl/diagProduct.sv
// walks the matrix diagonal and multiplies the elements into a running product
`timescale 1ns/10ps
`default_nettype none

module diagProduct #(
    parameter int mulLatency = 5
) (
    input  logic         clk,
    input  logic         arstN,
    input  logic         calcStart,
    input  detPkg::dimT  dim,
    output logic         calcDone,
    output detPkg::dataT product,
    detRamIf.reader      ram
);
    import detPkg::*;

    localparam int CNT_W = (mulLatency > 1) ? $clog2(mulLatency) : 1;

    typedef enum logic [1:0] {
        DP_IDLE,
        DP_READ,
        DP_DATA,
        DP_MUL
    } diagStateT;

    diagStateT        state;
    dataT             acc;
    dataT             mulOut;
    ramAddrT          idx;
    ramAddrT          stride;  // dim + 1 steps along the diagonal
    dimT              left;    // elements still to multiply
    logic [CNT_W-1:0] mulCnt;

    assign ram.rdEn   = (state == DP_READ);
    assign ram.rdAddr = idx;
    assign product    = acc;

    // rdData feeds the multiplier directly in the data cycle
    pipeMultiplier #(
        .mulLatency (mulLatency)
    ) mul_i (
        .clk   (clk),
        .arstN (arstN),
        .a     (acc),
        .b     (ram.rdData),
        .p     (mulOut)
    );

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= DP_IDLE;
            acc      <= '0;
            idx      <= '0;
            stride   <= '0;
            left     <= '0;
            mulCnt   <= '0;
            calcDone <= 1'b0;
        end else begin
            calcDone <= 1'b0;
            case (state)
                DP_IDLE: begin
                    if (calcStart) begin
                        acc    <= 32'd1;
                        idx    <= '0;
                        stride <= ramAddrT'(dim) + 1'b1;
                        left   <= dim;
                        state  <= DP_READ;
                    end
                end
                DP_READ: state <= DP_DATA;
                DP_DATA: begin
                    mulCnt <= '0;
                    if (ram.rdData == '0) begin
                        acc      <= '0;      // a zero pivot makes the determinant zero
                        calcDone <= 1'b1;
                        state    <= DP_IDLE;
                    end else begin
                        state <= DP_MUL;
                    end
                end
                DP_MUL: begin
                    if (mulCnt == CNT_W'(mulLatency - 1)) begin
                        acc <= mulOut;   // product leaves the pipe this cycle
                        if (left == dimT'(1)) begin
                            calcDone <= 1'b1;
                            state    <= DP_IDLE;
                        end else begin
                            left  <= left - 1'b1;
                            idx   <= idx + stride;
                            state <= DP_READ;
                        end
                    end else begin
                        mulCnt <= mulCnt + 1'b1;
                    end
                end
                default: state <= DP_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/matrixLoader.sv
// pipelined read master that copies a row-major matrix into local RAM
`timescale 1ns/10ps
`default_nettype none

module matrixLoader (
    input  logic            clk,
    input  logic            arstN,
    input  logic            loadStart,
    input  detPkg::busAddrT loadBase,
    input  detPkg::dimT     dim,
    input  detPkg::dataT    readdata,
    input  logic            readdatavalid,
    input  logic            waitrequest,
    output detPkg::busAddrT address,
    output logic            read,
    output logic            loadDone,
    detRamIf.writer         ram
);
    import detPkg::*;

    ramAddrT reqIdx;     // requests accepted so far
    ramAddrT wrIdx;      // words written so far
    ramAddrT lastIdx;    // dim*dim - 1
    logic    loading;
    logic    lastWrite;
    logic    reqAccept;

    assign reqAccept = read && !waitrequest;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            read      <= 1'b0;
            address   <= '0;
            reqIdx    <= '0;
            wrIdx     <= '0;
            lastIdx   <= '0;
            loading   <= 1'b0;
            lastWrite <= 1'b0;
            loadDone  <= 1'b0;
            ram.wrEn  <= 1'b0;
        end else begin
            loadDone  <= lastWrite;  // one cycle after the final write
            lastWrite <= 1'b0;
            ram.wrEn  <= 1'b0;
            if (loadStart) begin
                read    <= 1'b1;
                address <= loadBase;
                reqIdx  <= '0;
                wrIdx   <= '0;
                lastIdx <= ramAddrT'(dim * dim - 1);
                loading <= 1'b1;
            end else begin
                // address and read hold under waitrequest
                if (reqAccept) begin
                    if (reqIdx == lastIdx) begin
                        read <= 1'b0;
                    end else begin
                        address <= address + 24'd4;
                        reqIdx  <= reqIdx + 1'b1;
                    end
                end
                // words come back in request order
                if (readdatavalid && loading) begin
                    ram.wrEn <= 1'b1;
                    wrIdx    <= wrIdx + 1'b1;
                    if (wrIdx == lastIdx) begin
                        loading   <= 1'b0;
                        lastWrite <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (readdatavalid) begin
            ram.wrAddr <= wrIdx;
            ram.wrData <= readdata;
        end
    end

endmodule

`default_nettype wire

//--- rtl/matrixRam.sv
// simple dual-port matrix store with one-cycle registered read
`timescale 1ns/10ps
`default_nettype none

module matrixRam (
    input  logic clk,
    detRamIf.mem ram
);
    import detPkg::*;

    dataT store [RAM_DEPTH];   // row-major, MAX_DIM x MAX_DIM words

    always_ff @(posedge clk) begin
        if (ram.wrEn) begin
            store[ram.wrAddr] <= ram.wrData;
        end
    end

    always_ff @(posedge clk) begin
        if (ram.rdEn) begin
            ram.rdData <= store[ram.rdAddr];
        end
    end

endmodule

`default_nettype wire

//--- rtl/pipeMultiplier.sv
// 32-bit integer multiplier keeping the low word and delaying it through a register pipe
`timescale 1ns/10ps
`default_nettype none

module pipeMultiplier #(
    parameter int mulLatency = 5
) (
    input  logic         clk,
    input  logic         arstN,
    input  detPkg::dataT a,
    input  detPkg::dataT b,
    output detPkg::dataT p
);
    import detPkg::*;

    dataT prodLow;
    dataT pipe [mulLatency];

    // low word of the signed product wraps modulo 2^32
    assign prodLow = dataT'($signed(a) * $signed(b));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < mulLatency; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= prodLow;
            for (int i = 1; i < mulLatency; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign p = pipe[mulLatency-1];

endmodule

`default_nettype wire

//--- rtl/detRamIf.sv
// matrix RAM bundle with one write port and one registered read port
`timescale 1ns/10ps
`default_nettype none

interface detRamIf;
    import detPkg::*;

    logic    wrEn;
    ramAddrT wrAddr;
    dataT    wrData;
    logic    rdEn;
    ramAddrT rdAddr;
    dataT    rdData;   // valid the cycle after rdEn

    modport writer (
        output wrEn, wrAddr, wrData
    );

    modport reader (
        output rdEn, rdAddr,
        input  rdData
    );

    modport mem (
        input  wrEn, wrAddr, wrData, rdEn, rdAddr,
        output rdData
    );

endinterface

`default_nettype wire

//--- rtl/detPkg.sv
// determinant accelerator shared widths, status codes and limits
`default_nettype none

package detPkg;

    // largest supported matrix is MAX_DIM x MAX_DIM
    localparam int MAX_DIM   = 32;
    localparam int RAM_DEPTH = MAX_DIM * MAX_DIM;

    typedef logic [31:0]                    dataT;    // matrix word or result
    typedef logic [23:0]                    busAddrT; // byte address on the read master
    typedef logic [$clog2(RAM_DEPTH)-1:0]   ramAddrT; // word index into local RAM
    typedef logic [5:0]                     dimT;     // 2..32

    // custom-instruction replies
    localparam dataT STATUS_READY     = '1;
    localparam dataT STATUS_ACCEPTED  = 32'd99;
    localparam dataT STATUS_LOADING   = 32'd1;
    localparam dataT STATUS_COMPUTING = 32'd2;
    localparam dataT STATUS_IRQ_WAIT  = 32'd3;

    // controller stages
    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        CALC,
        IRQ_WAIT
    } stageT;

endpackage

`default_nettype wire
